// File: hw/bp_pkg.sv
// Shared types for the decode-stage branch predictor
// Addresses are 32-bit RV32 instruction addresses, compressed code is not handled
`default_nettype none

package bp_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // Saturating direction counter, upper bit set means taken
  typedef logic [1:0]  ctr_t;

  //////////////////////////////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////////////////////////////

  // Instruction class as seen by decode
  typedef enum logic [1:0] {OTHER, BRANCH, JAL, JALR} instr_kind_e;

  // Return address stack operation
  typedef enum logic [1:0] {NONE, PUSH, POP, BOTH} ras_op_e;

  // Origin of the next-fetch prediction
  typedef enum logic [1:0] {SEQ, BTB, RAS} pred_src_e;

  //////////////////////////////////////////////////////////////////////////
  // Interface structs
  //////////////////////////////////////////////////////////////////////////

  // Request from decode
  typedef struct packed {
    logic        valid;
    addr_t       pc;
    instr_kind_e kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    addr_t       return_addr;
  } bp_req_t;

  // Resolved branch or jump from execute
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  taken;
    addr_t target;
    logic  spec_hit;
  } bp_resolve_t;

  // Registered next-fetch prediction
  typedef struct packed {
    logic      valid;
    logic      taken;
    addr_t     target;
    pred_src_e src;
  } bp_pred_t;

endpackage

`default_nettype wire

// File: hw/ras.sv
// Return address stack driven by the RISC-V link register hints (x1, x5)
// Overflow silently drops the bottom entry, underflow returns stale data
// Repair only covers the single most recent pop
`timescale 1ns/1ns
`default_nettype none

module ras #(
  parameter int RasDepth = 8
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            stall_i,
  input  logic            spec_hit_i,
  input  bp_pkg::bp_req_t req_i,
  output bp_pkg::addr_t   ras_addr_o,
  output logic            ras_valid_o
);

  // Link registers per the calling convention
  localparam bp_pkg::reg_idx_t RegRa = 5'd1;
  localparam bp_pkg::reg_idx_t RegT0 = 5'd5;

  bp_pkg::addr_t   stack_q [RasDepth];
  bp_pkg::addr_t   popped_q;
  logic            pop_q;
  bp_pkg::ras_op_e op;
  logic            link_rd;
  logic            link_rs1;
  logic            repair;

  ////////////////////////////////////////////////////////////////////////////
  // Hint decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    link_rd  = (req_i.rd == RegRa) || (req_i.rd == RegT0);
    link_rs1 = (req_i.rs1 == RegRa) || (req_i.rs1 == RegT0);
    op       = bp_pkg::NONE;
    if (req_i.valid) begin
      if (req_i.kind == bp_pkg::JAL) begin
        // Call through jal
        if (link_rd) begin
          op = bp_pkg::PUSH;
        end
      end else if (req_i.kind == bp_pkg::JALR) begin
        if (link_rd && link_rs1) begin
          // Same register is a plain call, different ones a coroutine swap
          op = (req_i.rd == req_i.rs1) ? bp_pkg::PUSH : bp_pkg::BOTH;
        end else if (link_rs1) begin
          op = bp_pkg::POP;
        end else if (link_rd) begin
          op = bp_pkg::PUSH;
        end
      end
    end
  end

  // Prediction is always the current top
  assign ras_addr_o  = stack_q[0];
  assign ras_valid_o = (op == bp_pkg::POP) || (op == bp_pkg::BOTH);

  // Last pop turned out wrong, put the entry back
  assign repair = pop_q && !spec_hit_i;

  ////////////////////////////////////////////////////////////////////////////
  // Stack update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      stack_q <= '{default: '0};
    end else if (!stall_i) begin
      if (repair) begin
        // Repair wins over whatever decode asks for this cycle
        for (int i = RasDepth - 1; i > 0; i--) begin
          stack_q[i] <= stack_q[i-1];
        end
        stack_q[0] <= popped_q;
      end else begin
        case (op)
          bp_pkg::PUSH: begin
            for (int i = RasDepth - 1; i > 0; i--) begin
              stack_q[i] <= stack_q[i-1];
            end
            stack_q[0] <= req_i.return_addr;
          end
          bp_pkg::POP: begin
            for (int i = 0; i < RasDepth - 1; i++) begin
              stack_q[i] <= stack_q[i+1];
            end
          end
          bp_pkg::BOTH: stack_q[0] <= req_i.return_addr;
          default: ;
        endcase
      end
    end
  end

  // Remember the popped address for one cycle
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      popped_q <= '0;
      pop_q    <= 1'b0;
    end else if (!stall_i) begin
      popped_q <= ras_addr_o;
      pop_q    <= ras_valid_o;
    end
  end

endmodule

`default_nettype wire

// File: hw/btb.sv
// Direct-mapped branch target buffer with 2-bit direction counters
// BtbEntries must be a power of two, pc bits 1:0 are ignored
// Updates from execute are never stalled
`timescale 1ns/1ns
`default_nettype none

module btb #(
  parameter int BtbEntries = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  bp_pkg::addr_t       lookup_pc_i,
  input  bp_pkg::bp_resolve_t resolve_i,
  output logic                hit_o,
  output logic                taken_o,
  output bp_pkg::addr_t       target_o
);

  localparam int IdxWidth = $clog2(BtbEntries);
  localparam int TagWidth = 32 - 2 - IdxWidth;

  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [TagWidth-1:0] tag_t;

  // Entry storage, only the valid bits are cleared on reset
  logic          valid_q  [BtbEntries];
  tag_t          tag_q    [BtbEntries];
  bp_pkg::addr_t target_q [BtbEntries];
  bp_pkg::ctr_t  ctr_q    [BtbEntries];

  idx_t         lookup_idx;
  tag_t         lookup_tag;
  idx_t         upd_idx;
  tag_t         upd_tag;
  logic         upd_hit;
  bp_pkg::ctr_t upd_ctr;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  assign lookup_idx = lookup_pc_i[IdxWidth+1:2];
  assign lookup_tag = lookup_pc_i[31:IdxWidth+2];

  assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign taken_o  = hit_o && ctr_q[lookup_idx][1];
  assign target_o = target_q[lookup_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Update on resolve
  ////////////////////////////////////////////////////////////////////////////

  assign upd_idx = resolve_i.pc[IdxWidth+1:2];
  assign upd_tag = resolve_i.pc[31:IdxWidth+2];
  assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

  always_comb begin
    if (!upd_hit) begin
      // Fresh entry starts weakly biased toward the outcome
      upd_ctr = resolve_i.taken ? 2'd2 : 2'd1;
    end else if (resolve_i.taken) begin
      upd_ctr = (ctr_q[upd_idx] == 2'd3) ? 2'd3 : ctr_q[upd_idx] + 2'd1;
    end else begin
      upd_ctr = (ctr_q[upd_idx] == 2'd0) ? 2'd0 : ctr_q[upd_idx] - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      valid_q <= '{default: 1'b0};
    end else if (resolve_i.valid) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Tag, target and counter written on every resolve
  always_ff @(posedge clk_i) begin
    if (resolve_i.valid) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= resolve_i.target;
      ctr_q[upd_idx]    <= upd_ctr;
    end
  end

endmodule

`default_nettype wire

// File: hw/pc_select.sv
// Picks the next-fetch address from RAS, BTB or fall-through
// Output is registered, one cycle after the request
`timescale 1ns/1ns
`default_nettype none

module pc_select (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             stall_i,
  input  bp_pkg::bp_req_t  req_i,
  input  logic             ras_valid_i,
  input  bp_pkg::addr_t    ras_addr_i,
  input  logic             btb_hit_i,
  input  logic             btb_taken_i,
  input  bp_pkg::addr_t    btb_target_i,
  output bp_pkg::bp_pred_t pred_o
);

  bp_pkg::bp_pred_t pred_d;
  bp_pkg::bp_pred_t pred_q;
  bp_pkg::addr_t    seq_pc;

  // Fall-through address, 4-byte instructions only
  assign seq_pc = req_i.pc + 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    pred_d.valid = req_i.valid;
    if (ras_valid_i) begin
      // Returns trust the stack first
      pred_d.taken  = 1'b1;
      pred_d.target = ras_addr_i;
      pred_d.src    = bp_pkg::RAS;
    end else if (btb_hit_i && btb_taken_i) begin
      pred_d.taken  = 1'b1;
      pred_d.target = btb_target_i;
      pred_d.src    = bp_pkg::BTB;
    end else begin
      pred_d.taken  = 1'b0;
      pred_d.target = seq_pc;
      pred_d.src    = bp_pkg::SEQ;
    end
  end

  // Holds while the pipeline is stalled
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      pred_q <= '0;
    end else if (!stall_i) begin
      pred_q <= pred_d;
    end
  end

  assign pred_o = pred_q;

endmodule

`default_nettype wire

// File: hw/branch_predictor.sv
// Decode-stage branch predictor top, RAS and BTB side by side
// stall_i freezes all state except BTB training from execute
`timescale 1ns/1ns
`default_nettype none

module branch_predictor #(
  parameter int RasDepth   = 8,
  parameter int BtbEntries = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                stall_i,
  input  bp_pkg::bp_req_t     req_i,
  input  bp_pkg::bp_resolve_t resolve_i,
  output bp_pkg::bp_pred_t    pred_o
);

  // Predictor results toward the selector
  bp_pkg::addr_t ras_addr;
  logic          ras_valid;
  logic          btb_hit;
  logic          btb_taken;
  bp_pkg::addr_t btb_target;

  ////////////////////////////////////////////////////////////////////////////
  // Predictors
  ////////////////////////////////////////////////////////////////////////////

  ras #(
    .RasDepth(RasDepth)
  ) ras_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stall_i    (stall_i),
    .spec_hit_i (resolve_i.spec_hit),
    .req_i      (req_i),
    .ras_addr_o (ras_addr),
    .ras_valid_o(ras_valid)
  );

  btb #(
    .BtbEntries(BtbEntries)
  ) btb_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lookup_pc_i(req_i.pc),
    .resolve_i  (resolve_i),
    .hit_o      (btb_hit),
    .taken_o    (btb_taken),
    .target_o   (btb_target)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Final selection
  ////////////////////////////////////////////////////////////////////////////

  pc_select pc_select_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall_i),
    .req_i       (req_i),
    .ras_valid_i (ras_valid),
    .ras_addr_i  (ras_addr),
    .btb_hit_i   (btb_hit),
    .btb_taken_i (btb_taken),
    .btb_target_i(btb_target),
    .pred_o      (pred_o)
  );

endmodule

`default_nettype wire

// File: tb/branch_predictor_assert.sv
// Checks on the registered prediction, bound into the predictor top level
// Stall and source checks are off while reset is held
`timescale 1ns/1ns
`default_nettype none

module branch_predictor_assert (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             stall_i,
  input bp_pkg::bp_pred_t pred_i
);

  // Reset clears the prediction register
  valid_low_after_reset: assert property (@(posedge clk_i) rst_ni |=> !pred_i.valid)
    else $error("prediction valid in the cycle after reset");

  // Stall freezes the output
  hold_under_stall: assert property (@(posedge clk_i) disable iff (rst_ni)
    stall_i |=> $stable(pred_i))
    else $error("prediction changed while stalled");

  // A stack prediction is always a taken return
  ras_means_taken: assert property (@(posedge clk_i) disable iff (rst_ni)
    (pred_i.valid && pred_i.src == bp_pkg::RAS) |-> pred_i.taken)
    else $error("RAS prediction not marked taken");

endmodule

bind branch_predictor branch_predictor_assert branch_predictor_assert_inst (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .stall_i(stall_i),
  .pred_i (pred_o)
);

`default_nettype wire

// File: tb/branch_predictor_tb.sv
// Self-checking testbench for the branch predictor, one table row per clock cycle
// Expected predictions are filled in by hand from the RAS, BTB and priority rules
// Random return addresses and pcs come from a fixed seed
`timescale 1ns/1ns
`default_nettype none

module branch_predictor_tb;

  localparam int ClkPeriod = 20;
  localparam int NumGroups = 6;

  localparam bp_pkg::reg_idx_t Zero = 5'd0;
  localparam bp_pkg::reg_idx_t Ra   = 5'd1;
  localparam bp_pkg::reg_idx_t T0   = 5'd5;

  // One cycle of stimulus and the prediction expected one cycle later
  typedef struct packed {
    bp_pkg::bp_req_t     req;
    bp_pkg::bp_resolve_t res;
    logic                stall;
    bp_pkg::bp_pred_t    exp;
  } row_t;

  logic                clk_i;
  logic                rst_ni;
  logic                stall_i;
  bp_pkg::bp_req_t     req_i;
  bp_pkg::bp_resolve_t resolve_i;
  bp_pkg::bp_pred_t    pred_o;

  row_t  rows [$];
  int    row_grp [$];
  string grp_name [NumGroups];
  int    grp_checks [NumGroups];
  int    grp_errors [NumGroups];
  int    total_checks;
  int    total_errors;
  bit    table_ready;

  branch_predictor #(
    .RasDepth  (8),
    .BtbEntries(16)
  ) branch_predictor_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .stall_i  (stall_i),
    .req_i    (req_i),
    .resolve_i(resolve_i),
    .pred_o   (pred_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table helpers
  ////////////////////////////////////////////////////////////////////////////

  // Word aligned random address
  function automatic bp_pkg::addr_t random_word_addr();
    return $urandom & ~32'h3;
  endfunction

  function automatic bp_pkg::bp_req_t decode_req(bp_pkg::instr_kind_e kind,
      bp_pkg::addr_t pc, bp_pkg::reg_idx_t rd, bp_pkg::reg_idx_t rs1, bp_pkg::addr_t ret);
    bp_pkg::bp_req_t r;
    r.valid       = 1'b1;
    r.pc          = pc;
    r.kind        = kind;
    r.rd          = rd;
    r.rs1         = rs1;
    r.return_addr = ret;
    return r;
  endfunction

  function automatic bp_pkg::bp_resolve_t exec_resolve(logic valid, bp_pkg::addr_t pc,
      logic taken, bp_pkg::addr_t target, logic spec_hit);
    bp_pkg::bp_resolve_t r;
    r.valid    = valid;
    r.pc       = pc;
    r.taken    = taken;
    r.target   = target;
    r.spec_hit = spec_hit;
    return r;
  endfunction

  function automatic bp_pkg::bp_pred_t expected_pred(logic valid, logic taken,
      bp_pkg::addr_t target, bp_pkg::pred_src_e src);
    bp_pkg::bp_pred_t p;
    p.valid  = valid;
    p.taken  = taken;
    p.target = target;
    p.src    = src;
    return p;
  endfunction

  function automatic void push_row(bp_pkg::bp_req_t req, bp_pkg::bp_resolve_t res,
      logic stall, bp_pkg::bp_pred_t exp, int grp);
    row_t r;
    r.req   = req;
    r.res   = res;
    r.stall = stall;
    r.exp   = exp;
    rows.push_back(r);
    row_grp.push_back(grp);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    bp_pkg::addr_t       ra [8];
    bp_pkg::addr_t       pc [24];
    bp_pkg::bp_resolve_t quiet;
    bp_pkg::bp_pred_t    held;
    for (int i = 0; i < 8; i++) begin
      ra[i] = random_word_addr();
    end
    for (int i = 0; i < 24; i++) begin
      pc[i] = random_word_addr();
    end
    // No resolve, last pop counted as correct
    quiet = exec_resolve(1'b0, '0, 1'b0, '0, 1'b1);
    grp_name[0] = "reset and fall-through";
    grp_name[1] = "nested calls";
    grp_name[2] = "btb learning";
    grp_name[3] = "ras repair";
    grp_name[4] = "stall hold";
    grp_name[5] = "coroutine swap";

    // Idle request first, then a plain instruction
    push_row('0, quiet, 1'b0, expected_pred(1'b0, 1'b0, '0, bp_pkg::SEQ), 0);
    push_row(decode_req(bp_pkg::OTHER, pc[0], Zero, Zero, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[0] + 32'd4, bp_pkg::SEQ), 0);

    // Two calls then two returns, LIFO order
    push_row(decode_req(bp_pkg::JAL, pc[1], Ra, Zero, ra[0]), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[1] + 32'd4, bp_pkg::SEQ), 1);
    push_row(decode_req(bp_pkg::JAL, pc[2], Ra, Zero, ra[1]), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[2] + 32'd4, bp_pkg::SEQ), 1);
    push_row(decode_req(bp_pkg::JALR, pc[3], Zero, Ra, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[1], bp_pkg::RAS), 1);
    push_row(decode_req(bp_pkg::JALR, pc[4], Zero, Ra, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[0], bp_pkg::RAS), 1);

    // Branch at pc[5] with target pc[6], counter 2 then 1 then 0
    push_row(decode_req(bp_pkg::BRANCH, pc[5], Zero, Zero, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[5] + 32'd4, bp_pkg::SEQ), 2);
    push_row(decode_req(bp_pkg::OTHER, pc[7], Zero, Zero, '0),
             exec_resolve(1'b1, pc[5], 1'b1, pc[6], 1'b1), 1'b0,
             expected_pred(1'b1, 1'b0, pc[7] + 32'd4, bp_pkg::SEQ), 2);
    push_row(decode_req(bp_pkg::BRANCH, pc[5], Zero, Zero, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, pc[6], bp_pkg::BTB), 2);
    push_row(decode_req(bp_pkg::OTHER, pc[8], Zero, Zero, '0),
             exec_resolve(1'b1, pc[5], 1'b0, pc[6], 1'b1), 1'b0,
             expected_pred(1'b1, 1'b0, pc[8] + 32'd4, bp_pkg::SEQ), 2);
    push_row(decode_req(bp_pkg::OTHER, pc[9], Zero, Zero, '0),
             exec_resolve(1'b1, pc[5], 1'b0, pc[6], 1'b1), 1'b0,
             expected_pred(1'b1, 1'b0, pc[9] + 32'd4, bp_pkg::SEQ), 2);
    push_row(decode_req(bp_pkg::BRANCH, pc[5], Zero, Zero, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[5] + 32'd4, bp_pkg::SEQ), 2);

    // Push, pop, mispredict flag, then the same address pops again
    push_row(decode_req(bp_pkg::JAL, pc[10], T0, Zero, ra[2]), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[10] + 32'd4, bp_pkg::SEQ), 3);
    push_row(decode_req(bp_pkg::JALR, pc[11], Zero, Ra, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[2], bp_pkg::RAS), 3);
    push_row(decode_req(bp_pkg::OTHER, pc[12], Zero, Zero, '0),
             exec_resolve(1'b0, '0, 1'b0, '0, 1'b0), 1'b0,
             expected_pred(1'b1, 1'b0, pc[12] + 32'd4, bp_pkg::SEQ), 3);
    push_row(decode_req(bp_pkg::JALR, pc[13], Zero, T0, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[2], bp_pkg::RAS), 3);

    // Requests under stall are ignored and the pushed entry survives
    held = expected_pred(1'b1, 1'b0, pc[14] + 32'd4, bp_pkg::SEQ);
    push_row(decode_req(bp_pkg::JAL, pc[14], Ra, Zero, ra[3]), quiet, 1'b0, held, 4);
    push_row(decode_req(bp_pkg::JALR, pc[15], Zero, Ra, '0), quiet, 1'b1, held, 4);
    push_row(decode_req(bp_pkg::OTHER, pc[21], Zero, Zero, '0), quiet, 1'b1, held, 4);
    push_row(decode_req(bp_pkg::JALR, pc[22], Zero, Ra, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[3], bp_pkg::RAS), 4);

    // rd x1 with rs1 x5 replaces the top
    push_row(decode_req(bp_pkg::JAL, pc[16], Ra, Zero, ra[4]), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[16] + 32'd4, bp_pkg::SEQ), 5);
    push_row(decode_req(bp_pkg::JAL, pc[17], Ra, Zero, ra[5]), quiet, 1'b0,
             expected_pred(1'b1, 1'b0, pc[17] + 32'd4, bp_pkg::SEQ), 5);
    push_row(decode_req(bp_pkg::JALR, pc[18], Ra, T0, ra[6]), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[5], bp_pkg::RAS), 5);
    push_row(decode_req(bp_pkg::JALR, pc[19], Zero, Ra, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[6], bp_pkg::RAS), 5);
    push_row(decode_req(bp_pkg::JALR, pc[20], Zero, Ra, '0), quiet, 1'b0,
             expected_pred(1'b1, 1'b1, ra[4], bp_pkg::RAS), 5);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_row(input row_t r);
    req_i     = r.req;
    resolve_i = r.res;
    stall_i   = r.stall;
  endtask

  task automatic check_row(input int idx);
    row_t r;
    int   g;
    logic ok;
    r = rows[idx];
    g = row_grp[idx];
    // Only valid is defined for an idle request
    if (r.exp.valid) begin
      ok = (pred_o == r.exp);
    end else begin
      ok = !pred_o.valid;
    end
    grp_checks[g]++;
    total_checks++;
    assert (ok) else begin
      $display("FAILED at %0t ns: row %0d expected v=%0b t=%0b tgt=%h src=%0d,",
               $time, idx, r.exp.valid, r.exp.taken, r.exp.target, r.exp.src);
      $display("  got v=%0b t=%0b tgt=%h src=%0d",
               pred_o.valid, pred_o.taken, pred_o.target, pred_o.src);
      grp_errors[g]++;
      total_errors++;
    end
    // Group line once its last row is checked
    if (idx == rows.size() - 1 || row_grp[idx+1] != g) begin
      $display("group %0d %s: %0d checks, %0d errors",
               g, grp_name[g], grp_checks[g], grp_errors[g]);
    end
  endtask

  initial begin
    rst_ni       = 1'b1;
    stall_i      = 1'b0;
    // Decode stays busy through reset, only reset can clear the prediction
    req_i        = decode_req(bp_pkg::OTHER, 32'h0000_0100, Zero, Zero, '0);
    resolve_i    = '0;
    total_checks = 0;
    total_errors = 0;
    for (int g = 0; g < NumGroups; g++) begin
      grp_checks[g] = 0;
      grp_errors[g] = 0;
    end
    void'($urandom(32'hc242));
    fill_table();
    table_ready = 1'b1;
    repeat (8) @(negedge clk_i);
    // Last reset edge has passed, prediction register must be empty
    grp_checks[0]++;
    total_checks++;
    assert (!pred_o.valid) else begin
      $display("FAILED at %0t ns: prediction valid right after reset", $time);
      grp_errors[0]++;
      total_errors++;
    end
    rst_ni = 1'b0;
    // Each row is driven on a falling edge and checked on the next one
    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i]);
      @(negedge clk_i);
      check_row(i);
    end
    $display("summary: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog, table length plus margin
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (rows.size() + 20) * ClkPeriod;
    #(limit_ns);
    $display("ERROR: watchdog expired before all table rows were checked");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hw/bp_pkg.sv
hw/ras.sv
hw/btb.sv
hw/pc_select.sv
hw/branch_predictor.sv
tb/branch_predictor_assert.sv
tb/branch_predictor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the branch predictor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=branch_predictor_tb
obj_dir=obj_dir
log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert -f build.f --top-module "$top" \
    -Mdir "$obj_dir" -o sim_bin; then
  echo "verilator compile step failed"
  exit 1
fi

"./$obj_dir/sim_bin" > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$log"; then
  echo "failure reported in $log"
  exit 1
fi

exit 0
